// ==== logic/du_defs.svh ====
// Debug unit build constants
// Data width, breakpoint counts and debugger address split

`ifndef DU_DEFS_SVH
`define DU_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Data path
////////////////////////////////////////////////////////////////////////////

// Width of GPRs, PCs and debug data words
`define DU_XLEN 32

////////////////////////////////////////////////////////////////////////////
// Breakpoints
////////////////////////////////////////////////////////////////////////////

// Comparators actually built
`define DU_BREAKPOINTS 3

// Slots reserved in the debug register map
`define DU_MAX_BREAKPOINTS 8

////////////////////////////////////////////////////////////////////////////
// Debugger addressing
////////////////////////////////////////////////////////////////////////////

// Bank in the upper bits, register offset below
`define DU_DBG_ADDR_W 16
`define DU_ADDR_W 12

`endif

// ==== logic/du_cpu_pkg.sv ====
// Core side types seen by the debug unit
// Instruction words, opcodes, exception vectors and pipeline status

`include "du_defs.svh"

package du_cpu_pkg;

  // Major opcode, instr[6:2]
  typedef enum logic [4:0] {
    OPC_LOAD   = 5'b00000,
    OPC_STORE  = 5'b01000,
    OPC_BRANCH = 5'b11000
  } opcode_t;

  // Bubble marks an empty pipeline slot
  typedef struct packed {
    logic        bubble;
    logic [31:0] instr;
  } instruction_t;

  typedef struct packed {
    logic        any;
    logic [30:0] detail;
  } exceptions_t;

  // Pipeline signals watched by the breakpoint matcher
  typedef struct packed {
    instruction_t         pd_insn;
    logic [`DU_XLEN-1:0]  pd_pc;
    logic                 bu_flush;
    logic                 st_flush;
    instruction_t         mem_insn;
    exceptions_t          mem_exceptions;
    logic [`DU_XLEN-1:0]  mem_adr;
    logic                 dmem_ack;
  } pipe_status_t;

endpackage

// ==== logic/du_regs_pkg.sv ====
// Debug register map
// Banks, register offsets and the structs held by the register file

`include "du_defs.svh"

package du_regs_pkg;

  typedef enum logic [`DU_DBG_ADDR_W-`DU_ADDR_W-1:0] {
    DBG_INTERNAL = 4'h0,
    DBG_GPRS     = 4'h1,
    DBG_CSRS     = 4'h2
  } bank_t;

  // Internal bank, breakpoint n at BPCTRL0 + 2*n
  localparam logic [`DU_ADDR_W-1:0] DBG_CTRL    = 12'h000;
  localparam logic [`DU_ADDR_W-1:0] DBG_HIT     = 12'h001;
  localparam logic [`DU_ADDR_W-1:0] DBG_IE      = 12'h002;
  localparam logic [`DU_ADDR_W-1:0] DBG_CAUSE   = 12'h003;
  localparam logic [`DU_ADDR_W-1:0] DBG_BPCTRL0 = 12'h010;
  localparam logic [`DU_ADDR_W-1:0] DBG_BPDATA0 = 12'h011;

  // GPR bank, register number in the low five bits
  localparam logic [`DU_ADDR_W-1:0] DBG_GPR = 12'b0000_000?_????;
  localparam logic [`DU_ADDR_W-1:0] DBG_NPC = 12'h200;
  localparam logic [`DU_ADDR_W-1:0] DBG_PPC = 12'h201;

  typedef enum logic [2:0] {
    CC_FETCH    = 3'h0,
    CC_LD_ADR   = 3'h1,
    CC_ST_ADR   = 3'h2,
    CC_LDST_ADR = 3'h3
  } bp_cc_t;

  typedef struct packed {
    logic branch_break_ena;
    logic instr_break_ena;
  } dbg_ctrl_t;

  typedef struct packed {
    bp_cc_t cc;
    logic   enabled;
    logic   implemented;
  } bp_ctrl_t;

  typedef struct packed {
    bp_ctrl_t            ctrl;
    logic [`DU_XLEN-1:0] data;
  } bp_t;

  typedef struct packed {
    logic [`DU_MAX_BREAKPOINTS-1:0] bp_hit;
    logic                           branch_break_hit;
    logic                           instr_break_hit;
  } dbg_hit_t;

  typedef struct packed {
    logic                  we;
    logic [`DU_ADDR_W-1:0] addr;
    logic [`DU_XLEN-1:0]   data;
  } du_wreq_t;

  // Register view handed to the matcher
  typedef struct packed {
    dbg_ctrl_t                  ctrl;
    bp_t [`DU_BREAKPOINTS-1:0]  bp;
  } match_cfg_t;

  // One-cycle hit pulses from the matcher
  typedef struct packed {
    logic                       instr;
    logic                       branch;
    logic [`DU_BREAKPOINTS-1:0] bp;
  } hit_evt_t;

endpackage

// ==== logic/du_port.sv ====
// Debugger port of the debug unit
// Bank decode, acknowledge timing, write strobes and read data select

`include "du_defs.svh"

module du_port import du_regs_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      dbg_stall_i,
  input  logic                      dbg_strb_i,
  input  logic                      dbg_we_i,
  input  logic [`DU_DBG_ADDR_W-1:0] dbg_addr_i,
  input  logic [`DU_XLEN-1:0]       dbg_d_i,
  output logic [`DU_XLEN-1:0]       dbg_q_o,
  output logic                      dbg_ack_o,
  input  logic                      ex_stall_i,
  input  logic [`DU_XLEN-1:0]       int_q_i,
  input  logic [`DU_XLEN-1:0]       du_rf_q_i,
  input  logic [`DU_XLEN-1:0]       st_csr_q_i,
  input  logic [`DU_XLEN-1:0]       bu_nxt_pc_i,
  input  logic [`DU_XLEN-1:0]       ex_pc_i,
  output logic                      du_stall_o,
  output logic                      du_latch_nxt_pc_o,
  output logic                      du_flush_o,
  output logic                      du_we_rf_o,
  output logic                      du_we_pc_o,
  output logic                      du_we_csr_o,
  output logic [`DU_ADDR_W-1:0]     du_addr_o,
  output logic [`DU_XLEN-1:0]       du_d_o,
  output du_wreq_t                  wreq_o
);

  logic                  strb_dly_q;
  logic                  stall_dly_q;
  logic [`DU_ADDR_W-1:0] offs;
  logic                  sel_int;
  logic                  sel_gprs;
  logic                  sel_csrs;
  logic                  access;
  logic                  first_we;
  logic [2:0]            ack_q;
  logic                  we_int_q;

  ////////////////////////////////////////////////////////////////////////////
  // Decode and access
  ////////////////////////////////////////////////////////////////////////////

  assign offs     = dbg_addr_i[`DU_ADDR_W-1:0];
  assign sel_int  = dbg_addr_i[`DU_DBG_ADDR_W-1:`DU_ADDR_W] == DBG_INTERNAL;
  assign sel_gprs = dbg_addr_i[`DU_DBG_ADDR_W-1:`DU_ADDR_W] == DBG_GPRS;
  assign sel_csrs = dbg_addr_i[`DU_DBG_ADDR_W-1:`DU_ADDR_W] == DBG_CSRS;

  // Core registers only reachable while stalled
  assign access   = dbg_strb_i & (dbg_stall_i | sel_int);
  assign first_we = access & ~strb_dly_q & dbg_we_i;

  // Ack after three unstalled cycles, cleared right after the pulse
  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
      ack_q <= 3'b000;
    else if (!ex_stall_i || dbg_ack_o)
      ack_q <= {3{access & ~dbg_ack_o}} & {1'b1, ack_q[2:1]};

  assign dbg_ack_o = ack_q[0];

  ////////////////////////////////////////////////////////////////////////////
  // Write strobes and payload
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
    begin
      strb_dly_q  <= 1'b0;
      stall_dly_q <= 1'b0;
      we_int_q    <= 1'b0;
      du_we_rf_o  <= 1'b0;
      du_we_pc_o  <= 1'b0;
      du_we_csr_o <= 1'b0;
    end
    else
    begin
      strb_dly_q  <= dbg_strb_i;
      stall_dly_q <= dbg_stall_i;
      we_int_q    <= first_we & sel_int;
      du_we_rf_o  <= first_we & sel_gprs & (offs ==? DBG_GPR);
      du_we_pc_o  <= first_we & sel_gprs & (offs == DBG_NPC);
      du_we_csr_o <= first_we & sel_csrs;
    end

  always_ff @(posedge clk_i)
  begin
    du_addr_o <= offs;
    du_d_o    <= dbg_d_i;
  end

  assign wreq_o = '{we: we_int_q, addr: du_addr_o, data: du_d_o};

  // Read data, internal word decoded from the registered offset
  always_ff @(posedge clk_i)
    casez (dbg_addr_i)
      {DBG_INTERNAL, 12'b????_????_????}: dbg_q_o <= int_q_i;
      {DBG_GPRS, DBG_GPR}:                dbg_q_o <= du_rf_q_i;
      {DBG_GPRS, DBG_NPC}:                dbg_q_o <= bu_nxt_pc_i;
      {DBG_GPRS, DBG_PPC}:                dbg_q_o <= ex_pc_i;
      {DBG_CSRS, 12'b????_????_????}:     dbg_q_o <= st_csr_q_i;
      default:                            dbg_q_o <= '0;
    endcase

  ////////////////////////////////////////////////////////////////////////////
  // Stall edges
  ////////////////////////////////////////////////////////////////////////////

  assign du_stall_o        = dbg_stall_i;
  // Capture next PC on entry, refetch on exit
  assign du_latch_nxt_pc_o = dbg_stall_i & ~stall_dly_q;
  assign du_flush_o        = ~dbg_stall_i & stall_dly_q;

  ack_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dbg_ack_o |=> !dbg_ack_o);

endmodule

// ==== logic/du_regfile.sv ====
// Debug unit register file
// Control, sticky hits, interrupt enables, cause and breakpoint registers

`include "du_defs.svh"

module du_regfile import du_regs_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  du_wreq_t            wreq_i,
  input  hit_evt_t            hit_i,
  input  logic [31:0]         du_exceptions_i,
  output logic [`DU_XLEN-1:0] int_q_o,
  output match_cfg_t          cfg_o,
  output dbg_hit_t            hits_o,
  output logic [31:0]         du_ie_o
);

  localparam int SLOT_W = $clog2(`DU_MAX_BREAKPOINTS);

  dbg_ctrl_t                  ctrl_q;
  logic [31:0]                ie_q;
  logic [`DU_XLEN-1:0]        cause_q;
  logic                       instr_hit_q;
  logic                       branch_hit_q;
  logic [`DU_BREAKPOINTS-1:0] bp_hit_q;
  bp_cc_t                     bp_cc_q   [`DU_BREAKPOINTS];
  logic [`DU_BREAKPOINTS-1:0] bp_ena_q;
  logic [`DU_XLEN-1:0]        bp_data_q [`DU_BREAKPOINTS];
  bp_t [`DU_MAX_BREAKPOINTS-1:0] bp_view;
  logic [`DU_ADDR_W-1:0]      bp_offs;
  logic                       bp_sel;
  logic [SLOT_W-1:0]          bp_slot;

  // Lowest set bit wins
  function automatic logic [3:0] lowest_set(input logic [15:0] v);
    logic [3:0] idx;
    idx = 4'd0;
    for (int i = 15; i >= 0; i--)
      if (v[i])
        idx = i[3:0];
    return idx;
  endfunction

  assign bp_offs = wreq_i.addr - DBG_BPCTRL0;
  assign bp_sel  = bp_offs < 2 * `DU_MAX_BREAKPOINTS;
  assign bp_slot = bp_offs[SLOT_W:1];

  ////////////////////////////////////////////////////////////////////////////
  // Control, enables and cause
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
    begin
      ctrl_q <= '0;
      ie_q   <= '0;
    end
    else if (wreq_i.we)
    begin
      if (wreq_i.addr == DBG_CTRL)
        ctrl_q <= wreq_i.data[1:0];
      if (wreq_i.addr == DBG_IE)
        ie_q <= wreq_i.data[31:0];
    end

  // Debugger write, then traps, then interrupts
  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
      cause_q <= '0;
    else if (wreq_i.we && wreq_i.addr == DBG_CAUSE)
      cause_q <= wreq_i.data;
    else if (|du_exceptions_i[15:0])
      cause_q <= {{(`DU_XLEN-4){1'b0}}, lowest_set(du_exceptions_i[15:0])};
    else if (|du_exceptions_i[31:16])
      cause_q <= {1'b1, {(`DU_XLEN-5){1'b0}}, lowest_set(du_exceptions_i[31:16])};

  // Sticky until the debugger rewrites DBG_HIT
  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
    begin
      instr_hit_q  <= 1'b0;
      branch_hit_q <= 1'b0;
      bp_hit_q     <= '0;
    end
    else if (wreq_i.we && wreq_i.addr == DBG_HIT)
    begin
      instr_hit_q  <= wreq_i.data[0];
      branch_hit_q <= wreq_i.data[1];
      bp_hit_q     <= wreq_i.data[8 +: `DU_BREAKPOINTS];
    end
    else
    begin
      instr_hit_q  <= instr_hit_q | hit_i.instr;
      branch_hit_q <= branch_hit_q | hit_i.branch;
      bp_hit_q     <= bp_hit_q | hit_i.bp;
    end

  ////////////////////////////////////////////////////////////////////////////
  // Breakpoint slots
  ////////////////////////////////////////////////////////////////////////////

  for (genvar n = 0; n < `DU_MAX_BREAKPOINTS; n++)
  begin : gen_bp
    if (n < `DU_BREAKPOINTS)
    begin : gen_impl
      always_ff @(posedge clk_i or negedge rst_ni)
        if (!rst_ni)
        begin
          bp_cc_q[n]   <= CC_FETCH;
          bp_ena_q[n]  <= 1'b0;
          bp_data_q[n] <= '0;
        end
        else if (wreq_i.we && wreq_i.addr == DBG_BPCTRL0 + 2 * n)
        begin
          bp_cc_q[n]  <= bp_cc_t'(wreq_i.data[6:4]);
          bp_ena_q[n] <= wreq_i.data[1];
        end
        else if (wreq_i.we && wreq_i.addr == DBG_BPDATA0 + 2 * n)
          bp_data_q[n] <= wreq_i.data;

      assign bp_view[n] = '{ctrl: '{cc: bp_cc_q[n], enabled: bp_ena_q[n], implemented: 1'b1},
                            data: bp_data_q[n]};
    end
    else
    begin : gen_empty
      assign bp_view[n] = '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs and readback
  ////////////////////////////////////////////////////////////////////////////

  assign cfg_o.ctrl = ctrl_q;
  assign cfg_o.bp   = bp_view[`DU_BREAKPOINTS-1:0];
  assign du_ie_o    = ie_q;

  assign hits_o.bp_hit           = {{(`DU_MAX_BREAKPOINTS-`DU_BREAKPOINTS){1'b0}}, bp_hit_q};
  assign hits_o.branch_break_hit = branch_hit_q;
  assign hits_o.instr_break_hit  = instr_hit_q;

  always_comb
  begin
    int_q_o = '0;
    if (bp_sel && bp_offs[0])
      int_q_o = bp_view[bp_slot].data;
    else if (bp_sel)
      int_q_o[6:0] = {bp_view[bp_slot].ctrl.cc, 2'b00, bp_view[bp_slot].ctrl.enabled,
                      bp_view[bp_slot].ctrl.implemented};
    else
      case (wreq_i.addr)
        DBG_CTRL:  int_q_o[1:0] = ctrl_q;
        DBG_HIT:   int_q_o[15:0] = {hits_o.bp_hit, 6'h00, branch_hit_q, instr_hit_q};
        DBG_IE:    int_q_o[31:0] = ie_q;
        DBG_CAUSE: int_q_o = cause_q;
        default:   int_q_o = '0;
      endcase
  end

  // Writes into unbuilt slots leave the built comparators alone
  unimpl_bp_write_ignored: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wreq_i.we && bp_sel && bp_slot >= `DU_BREAKPOINTS) |=> $stable(cfg_o.bp));

endmodule

// ==== logic/du_bp_match.sv ====
// Breakpoint matcher
// Single-step, branch and address breakpoint hits from pipeline status

`include "du_defs.svh"

module du_bp_match import du_cpu_pkg::*, du_regs_pkg::*;
(
  input  match_cfg_t   cfg_i,
  input  pipe_status_t pipe_i,
  output hit_evt_t     hit_o
);

  logic                       pd_valid;
  logic                       mem_ok;
  logic                       mem_read;
  logic                       mem_write;
  logic                       adr_match;
  logic [`DU_BREAKPOINTS-1:0] bp_hit;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction events
  ////////////////////////////////////////////////////////////////////////////

  assign pd_valid = ~pipe_i.pd_insn.bubble;

  assign hit_o.instr  = cfg_i.ctrl.instr_break_ena & pd_valid;
  assign hit_o.branch = cfg_i.ctrl.branch_break_ena & pd_valid &
                        (pipe_i.pd_insn.instr[6:2] == OPC_BRANCH);

  ////////////////////////////////////////////////////////////////////////////
  // Breakpoint compare
  ////////////////////////////////////////////////////////////////////////////

  // Only completed accesses without exception count
  assign mem_ok    = ~pipe_i.mem_exceptions.any & ~pipe_i.mem_insn.bubble & pipe_i.dmem_ack;
  assign mem_read  = mem_ok & (pipe_i.mem_insn.instr[6:2] == OPC_LOAD);
  assign mem_write = mem_ok & (pipe_i.mem_insn.instr[6:2] == OPC_STORE);

  always_comb
  begin
    bp_hit    = '0;
    adr_match = 1'b0;
    for (int n = 0; n < `DU_BREAKPOINTS; n++)
    begin
      adr_match = pipe_i.mem_adr == cfg_i.bp[n].data;
      if (cfg_i.bp[n].ctrl.enabled)
        case (cfg_i.bp[n].ctrl.cc)
          CC_FETCH:
            bp_hit[n] = (pipe_i.pd_pc == cfg_i.bp[n].data) &
                        ~pipe_i.bu_flush & ~pipe_i.st_flush;
          CC_LD_ADR:   bp_hit[n] = adr_match & mem_read;
          CC_ST_ADR:   bp_hit[n] = adr_match & mem_write;
          CC_LDST_ADR: bp_hit[n] = adr_match & (mem_read | mem_write);
          default:     bp_hit[n] = 1'b0;
        endcase
    end
  end

  assign hit_o.bp = bp_hit;

endmodule

// ==== logic/riscv_du.sv ====
// Debug unit top level
// Connects debugger port, register file and breakpoint matcher

`include "du_defs.svh"

module riscv_du import du_cpu_pkg::*, du_regs_pkg::*;
(
  input  logic                      rst_ni,
  input  logic                      clk_i,
  input  logic                      dbg_stall_i,
  input  logic                      dbg_strb_i,
  input  logic                      dbg_we_i,
  input  logic [`DU_DBG_ADDR_W-1:0] dbg_addr_i,
  input  logic [`DU_XLEN-1:0]       dbg_d_i,
  output logic [`DU_XLEN-1:0]       dbg_q_o,
  output logic                      dbg_ack_o,
  output logic                      dbg_bp_o,
  input  logic                      ex_stall_i,
  input  logic [`DU_XLEN-1:0]       du_rf_q_i,
  input  logic [`DU_XLEN-1:0]       st_csr_q_i,
  input  logic [`DU_XLEN-1:0]       bu_nxt_pc_i,
  input  logic [`DU_XLEN-1:0]       ex_pc_i,
  output logic                      du_stall_o,
  output logic                      du_latch_nxt_pc_o,
  output logic                      du_flush_o,
  output logic                      du_we_rf_o,
  output logic                      du_we_pc_o,
  output logic                      du_we_csr_o,
  output logic [`DU_ADDR_W-1:0]     du_addr_o,
  output logic [`DU_XLEN-1:0]       du_d_o,
  output logic [31:0]               du_ie_o,
  input  pipe_status_t              pipe_i,
  input  logic [31:0]               du_exceptions_i
);

  du_wreq_t            wreq;
  logic [`DU_XLEN-1:0] int_q;
  match_cfg_t          cfg;
  hit_evt_t            hit_evt;
  dbg_hit_t            hits;

  du_port u_port (
    .clk_i, .rst_ni, .dbg_stall_i, .dbg_strb_i, .dbg_we_i, .dbg_addr_i, .dbg_d_i,
    .dbg_q_o, .dbg_ack_o, .ex_stall_i, .int_q_i(int_q), .du_rf_q_i, .st_csr_q_i,
    .bu_nxt_pc_i, .ex_pc_i, .du_stall_o, .du_latch_nxt_pc_o, .du_flush_o,
    .du_we_rf_o, .du_we_pc_o, .du_we_csr_o, .du_addr_o, .du_d_o, .wreq_o(wreq)
  );

  du_regfile u_regfile (
    .clk_i, .rst_ni, .wreq_i(wreq), .hit_i(hit_evt), .du_exceptions_i,
    .int_q_o(int_q), .cfg_o(cfg), .hits_o(hits), .du_ie_o
  );

  du_bp_match u_bp_match (.cfg_i(cfg), .pipe_i, .hit_o(hit_evt));

  // Break request, held off while the core is stalled or flushing
  always_ff @(posedge clk_i or negedge rst_ni)
    if (!rst_ni)
      dbg_bp_o <= 1'b0;
    else
      dbg_bp_o <= ~ex_stall_i & ~du_stall_o & ~du_flush_o & ~pipe_i.st_flush &
                  ((|du_exceptions_i) | (|hits));

endmodule

// ==== verif/tb_du.sv ====
// Testbench for the debug unit top level
// Replays the operations in du_patterns.txt and checks port and hit results

`include "du_defs.svh"

module tb_du import du_cpu_pkg::*, du_regs_pkg::*;
();

  logic                      clk_i;
  logic                      rst_ni;
  logic                      dbg_stall_i;
  logic                      dbg_strb_i;
  logic                      dbg_we_i;
  logic [`DU_DBG_ADDR_W-1:0] dbg_addr_i;
  logic [`DU_XLEN-1:0]       dbg_d_i;
  logic [`DU_XLEN-1:0]       dbg_q_o;
  logic                      dbg_ack_o;
  logic                      dbg_bp_o;
  logic                      ex_stall_i;
  logic [`DU_XLEN-1:0]       du_rf_q_i;
  logic [`DU_XLEN-1:0]       st_csr_q_i;
  logic [`DU_XLEN-1:0]       bu_nxt_pc_i;
  logic [`DU_XLEN-1:0]       ex_pc_i;
  logic                      du_stall_o;
  logic                      du_latch_nxt_pc_o;
  logic                      du_flush_o;
  logic                      du_we_rf_o;
  logic                      du_we_pc_o;
  logic                      du_we_csr_o;
  logic [`DU_ADDR_W-1:0]     du_addr_o;
  logic [`DU_XLEN-1:0]       du_d_o;
  logic [31:0]               du_ie_o;
  pipe_status_t              pipe_i;
  logic [31:0]               du_exceptions_i;

  integer      seed;
  int          cycle_cnt;
  int          cycle_limit;
  logic [7:0]  op_q[$];
  logic [15:0] addr_q[$];
  logic [31:0] data_q[$];
  logic [31:0] exp_q[$];

  riscv_du dut0 (.*);

  always #10 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Failure reporting and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [`DU_XLEN-1:0] exp,
                            input logic [`DU_XLEN-1:0] act);
    if (exp !== act)
      abort_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_hit(input string name, input dbg_hit_t exp, input dbg_hit_t act);
    if (exp !== act)
      abort_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_pulse(input string name, input logic exp, input logic act);
    if (exp !== act)
      abort_run($sformatf("ERR %s expected %b actual %b", name, exp, act));
  endtask

  // Run cap, from the pattern count
  always @(posedge clk_i)
  begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit)
      abort_run($sformatf("Timeout: run still busy after %0d cycles", cycle_limit));
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic idle_pipe();
    pipe_i                        = '0;
    pipe_i.pd_insn.bubble         = 1'b1;
    pipe_i.mem_insn.bubble        = 1'b1;
  endtask

  // One debugger access; counts pass-through write strobes on the way
  task automatic bus_access(input logic we, input logic [15:0] addr, input logic [31:0] d,
                            input logic want_ack, input string name,
                            output logic [31:0] q, output int rf_cnt, output int pc_cnt,
                            output int csr_cnt, output logic [11:0] a_seen,
                            output logic [31:0] d_seen);
    int   n;
    logic got;
    n       = 0;
    got     = 1'b0;
    q       = '0;
    rf_cnt  = 0;
    pc_cnt  = 0;
    csr_cnt = 0;
    a_seen  = '0;
    d_seen  = '0;
    @(posedge clk_i);
    #2;
    dbg_strb_i = 1'b1;
    dbg_we_i   = we;
    dbg_addr_i = addr;
    dbg_d_i    = d;
    while (!got && n < 10)
    begin
      @(posedge clk_i);
      #1;
      n++;
      if (du_we_rf_o)
        rf_cnt++;
      if (du_we_pc_o)
        pc_cnt++;
      if (du_we_csr_o)
        csr_cnt++;
      if (du_we_rf_o || du_we_pc_o || du_we_csr_o)
      begin
        a_seen = du_addr_o;
        d_seen = du_d_o;
      end
      if (dbg_ack_o)
      begin
        got = 1'b1;
        q   = dbg_q_o;
      end
    end
    if (want_ack && !got)
      abort_run($sformatf("%s: no acknowledge within 10 cycles", name));
    if (want_ack && n != 3)
      abort_run($sformatf("%s: acknowledge came in cycle %0d, not 3", name, n));
    if (!want_ack && got)
      abort_run($sformatf("%s: access to the running core was acknowledged", name));
    @(posedge clk_i);
    #2;
    dbg_strb_i = 1'b0;
    dbg_we_i   = 1'b0;
  endtask

  // Sticky hit bits as laid out in DBG_HIT
  task automatic read_hits(input string name, output dbg_hit_t hits);
    logic [31:0] q;
    int          rf_cnt;
    int          pc_cnt;
    int          csr_cnt;
    logic [11:0] a_seen;
    logic [31:0] d_seen;
    bus_access(1'b0, {DBG_INTERNAL, DBG_HIT}, '0, 1'b1, name, q, rf_cnt, pc_cnt, csr_cnt,
               a_seen, d_seen);
    hits = '{bp_hit: q[15:8], branch_break_hit: q[1], instr_break_hit: q[0]};
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    int          fd;
    int          cnt;
    string       line;
    logic [7:0]  op;
    logic [15:0] a;
    logic [31:0] d;
    logic [31:0] e;
    logic [31:0] q;
    int          rf_cnt;
    int          pc_cnt;
    int          csr_cnt;
    logic [11:0] a_seen;
    logic [31:0] d_seen;
    dbg_hit_t    hits;
    string       name;

    seed            = 32'hcbb2;
    cycle_cnt       = 0;
    cycle_limit     = 1000;
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    dbg_stall_i     = 1'b0;
    dbg_strb_i      = 1'b0;
    dbg_we_i        = 1'b0;
    dbg_addr_i      = '0;
    dbg_d_i         = '0;
    ex_stall_i      = 1'b0;
    du_rf_q_i       = '0;
    st_csr_q_i      = $random(seed);
    bu_nxt_pc_i     = '0;
    ex_pc_i         = $random(seed);
    du_exceptions_i = '0;
    idle_pipe();

    fd = $fopen("verif/du_patterns.txt", "r");
    if (fd == 0)
      abort_run("Pattern file verif/du_patterns.txt could not be opened");
    while (!$feof(fd))
    begin
      cnt = $fgets(line, fd);
      if (cnt > 0 && line.len() > 1 && line.substr(0, 1) != "//")
        if ($sscanf(line, "%h %h %h %h", op, a, d, e) == 4)
        begin
          op_q.push_back(op);
          addr_q.push_back(a);
          data_q.push_back(d);
          exp_q.push_back(e);
        end
    end
    $fclose(fd);
    cycle_limit = op_q.size() * 10 + 8;

    repeat (8) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    for (int i = 0; i < op_q.size(); i++)
    begin
      a    = addr_q[i];
      d    = data_q[i];
      e    = exp_q[i];
      name = $sformatf("pattern %0d addr %h", i, a);
      case (op_q[i])
        // Write, expected field is the pass-through strobe code
        8'h0:
        begin
          if (a == {DBG_INTERNAL, DBG_CTRL})
            d = d | ($random(seed) & ~32'h3);
          bus_access(1'b1, a, d, 1'b1, name, q, rf_cnt, pc_cnt, csr_cnt, a_seen, d_seen);
          check_pulse({name, " we_rf"}, e[0], rf_cnt != 0);
          check_pulse({name, " we_pc"}, e[1], pc_cnt != 0);
          check_pulse({name, " we_csr"}, e[2], csr_cnt != 0);
          if (rf_cnt > 1 || pc_cnt > 1 || csr_cnt > 1)
            abort_run($sformatf("%s: write strobe held longer than one cycle", name));
          if (e[2:0] != 3'b000)
          begin
            check_word({name, " du_addr"}, {20'h0, a[11:0]}, {20'h0, a_seen});
            check_word({name, " du_d"}, d, d_seen);
          end
        end
        8'h1:
        begin
          // Only the addressed core source carries the expected word
          du_rf_q_i   = ~d;
          bu_nxt_pc_i = ~d;
          if (a == {DBG_GPRS, DBG_NPC})
            bu_nxt_pc_i = d;
          else
            du_rf_q_i = d;
          bus_access(1'b0, a, '0, 1'b1, name, q, rf_cnt, pc_cnt, csr_cnt, a_seen, d_seen);
          check_word({name, " read"}, e, q);
          if (a == {DBG_INTERNAL, DBG_IE})
            check_word({name, " du_ie"}, e, du_ie_o);
        end
        // Pipeline events last one cycle, then the sticky bits are read
        8'h2, 8'h3, 8'h8:
        begin
          @(posedge clk_i);
          #2;
          if (op_q[i] == 8'h2)
          begin
            pipe_i.pd_pc    = {16'h0, a};
            pipe_i.bu_flush = d[0];
          end
          else if (op_q[i] == 8'h3)
          begin
            pipe_i.mem_insn           = '{bubble: 1'b0, instr: {25'h0, d[4:0], 2'b11}};
            pipe_i.mem_exceptions.any = d[8];
            pipe_i.mem_adr            = {16'h0, a};
            pipe_i.dmem_ack           = 1'b1;
          end
          else
            pipe_i.pd_insn = '{bubble: 1'b0, instr: d};
          @(posedge clk_i);
          #2;
          idle_pipe();
          read_hits(name, hits);
          check_hit({name, " hits"}, dbg_hit_t'(e[9:0]), hits);
        end
        8'h4:
        begin
          @(posedge clk_i);
          #2;
          du_exceptions_i = d;
          @(posedge clk_i);
          #2;
          du_exceptions_i = '0;
        end
        8'h5:
        begin
          @(posedge clk_i);
          #2;
          dbg_stall_i = d[0];
          #1;
          check_pulse({name, " stall"}, d[0], du_stall_o);
          check_pulse({name, " latch_nxt_pc"}, d[0], du_latch_nxt_pc_o);
          check_pulse({name, " flush"}, ~d[0], du_flush_o);
          @(posedge clk_i);
          #1;
          check_pulse({name, " latch_nxt_pc end"}, 1'b0, du_latch_nxt_pc_o);
          check_pulse({name, " flush end"}, 1'b0, du_flush_o);
        end
        8'h6:
          bus_access(1'b0, a, '0, 1'b0, name, q, rf_cnt, pc_cnt, csr_cnt, a_seen, d_seen);
        8'h7:
        begin
          @(posedge clk_i);
          #1;
          check_pulse({name, " dbg_bp"}, e[0], dbg_bp_o);
        end
        default:
          abort_run($sformatf("%s: unknown operation code %h", name, op_q[i]));
      endcase
    end

    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== verif/du_patterns.txt ====
// op addr data expected, all hex; ops 0 write 1 read 2 fetch 3 mem 4 exception
// 5 stall level 6 read without ack 7 dbg_bp check 8 pd instruction
0 0000 00000002 0
1 0000 00000000 00000002
0 0000 00000000 0
0 0002 a5a50f0f 0
1 0002 00000000 a5a50f0f
0 0011 00001000 0
1 0011 00000000 00001000
0 0010 00000010 0
1 0010 00000000 00000011
0 0013 00002000 0
1 0013 00000000 00002000
0 0012 00000030 0
1 0012 00000000 00000031
0 0015 00003000 0
1 0015 00000000 00003000
0 0014 00000020 0
1 0014 00000000 00000021
0 0016 12345678 0
1 0016 00000000 00000000
1 0017 00000000 00000000
1 001e 00000000 00000000
0 0010 00000002 0
2 1000 00000001 000
7 0000 00000000 0
2 1000 00000000 004
7 0000 00000000 1
0 0001 00000000 0
1 0001 00000000 00000000
7 0000 00000000 0
0 0011 00004000 0
0 0010 00000022 0
0 0012 00000012 0
0 0014 00000032 0
3 2000 00000000 008
0 0001 00000000 0
3 2000 00000008 000
3 2000 00000100 000
3 4000 00000008 004
3 4000 00000000 004
0 0001 00000000 0
3 3000 00000000 010
3 3000 00000008 010
0 0001 00000000 0
3 3000 00000018 000
0 0010 00000000 0
0 0012 00000000 0
0 0014 00000000 0
4 0000 00000028 0
1 0003 00000000 00000003
4 0000 00050000 0
1 0003 00000000 80000000
4 0000 00400000 0
1 0003 00000000 80000006
4 0000 80008000 0
1 0003 00000000 0000000f
0 0003 00000007 0
1 0003 00000000 00000007
5 0000 00000001 0
0 1005 cafe0001 1
1 1005 0badf00d 0badf00d
0 1200 00000400 2
1 1200 00000444 00000444
5 0000 00000000 0
6 1005 00000000 0
0 0000 00000001 0
8 0000 00000013 001
0 0001 00000000 0
0 0000 00000000 0

// ==== tb.f ====
+incdir+logic
logic/du_cpu_pkg.sv
logic/du_regs_pkg.sv
logic/du_port.sv
logic/du_regfile.sv
logic/du_bp_match.sv
logic/riscv_du.sv
verif/tb_du.sv

// ==== Bender.yml ====
package:
  name: riscv_du

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/du_cpu_pkg.sv
      - logic/du_regs_pkg.sv
      - logic/du_port.sv
      - logic/du_regfile.sv
      - logic/du_bp_match.sv
      - logic/riscv_du.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/tb_du.sv
